//--- Makefile
BUILD_DIR = build

.PHONY: sim clean

sim:
	verilator --binary --timing -f project.f --top-module pipe_cpu_tb \
		-Mdir $(BUILD_DIR) -o pipe_cpu_tb
	./$(BUILD_DIR)/pipe_cpu_tb | tee /dev/stderr | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/pipe_cpu_tb.sv
module pipe_cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // standard MIPS encodings
    localparam logic [5:0] enc_rtype = 6'h00;
    localparam logic [5:0] enc_beq   = 6'h04;
    localparam logic [5:0] enc_bne   = 6'h05;
    localparam logic [5:0] enc_addiu = 6'h09;
    localparam logic [5:0] enc_lw    = 6'h23;
    localparam logic [5:0] enc_sw    = 6'h2b;
    localparam logic [5:0] enc_addu  = 6'h21;
    localparam logic [5:0] enc_subu  = 6'h23;
    localparam logic [5:0] enc_and   = 6'h24;
    localparam logic [5:0] enc_or    = 6'h25;
    localparam logic [5:0] enc_slt   = 6'h2a;
    localparam mips_pkg::word_t self_loop = 32'h1000ffff;  // beq $0,$0,-1

    logic            clk;
    logic            reset;
    mips_pkg::word_t imem_addr;
    mips_pkg::word_t imem_data;
    mips_pkg::word_t dmem_addr;
    logic            dmem_we;
    mips_pkg::word_t dmem_wdata;
    mips_pkg::word_t dmem_rdata;

    mips_pkg::word_t imem [256];
    mips_pkg::word_t dmem [256];
    mips_pkg::word_t exp_addr [$];
    mips_pkg::word_t exp_data [$];

    int   prog_len;
    int   errors;
    int   stores_seen;
    int   tests_run;
    int   tests_failed;
    logic checking;

    pipe_cpu #(
        .RESET_PC (32'h0)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // combinational word-addressed memories
    assign imem_data  = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    // **************************************************
    // helpers
    // **************************************************

    function automatic mips_pkg::word_t fill_word(input mips_pkg::word_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h6a09e667;
    endfunction

    function automatic int rand_imm();
        return int'($urandom() & 32'h0000ffff);
    endfunction

    task automatic check_value(input string name, input mips_pkg::word_t got,
                               input mips_pkg::word_t want);
        if (got !== want) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, want);
            errors++;
        end
    endtask

    task automatic emit_r(input int fn, input int rd, input int rs, input int rt);
        imem[prog_len] = {enc_rtype, rs[4:0], rt[4:0], rd[4:0], 5'b0, fn[5:0]};
        prog_len++;
    endtask

    // for sw and lw rt is the data register and rs the base
    task automatic emit_i(input int op, input int rt, input int rs, input int imm);
        imem[prog_len] = {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
        prog_len++;
    endtask

    // **************************************************
    // ISA-level reference without a delay slot
    // **************************************************

    function automatic void reference_stores();
        mips_pkg::word_t regs [32];
        mips_pkg::word_t mem [256];
        mips_pkg::word_t pc;
        mips_pkg::word_t instr;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t imm;
        mips_pkg::word_t addr;
        mips_pkg::word_t res;
        logic [4:0]      dst;
        logic            wr;
        int              steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        exp_addr.delete();
        exp_data.delete();
        pc = '0;
        steps = 0;
        while (steps < 4000) begin
            instr = imem[pc[7:0]];
            if (instr == self_loop) begin
                break;
            end
            a    = regs[instr[25:21]];
            b    = regs[instr[20:16]];
            imm  = {{16{instr[15]}}, instr[15:0]};
            addr = a + imm;
            wr   = 1'b0;
            dst  = instr[20:16];
            res  = '0;
            pc   = pc + 32'd1;
            case (instr[31:26])
                enc_rtype: begin
                    wr  = 1'b1;
                    dst = instr[15:11];
                    case (instr[5:0])
                        enc_addu: res = a + b;
                        enc_subu: res = a - b;
                        enc_and:  res = a & b;
                        enc_or:   res = a | b;
                        enc_slt:  res = {31'b0, $signed(a) < $signed(b)};
                        default:  wr = 1'b0;  // unknown funct
                    endcase
                end
                enc_addiu: begin
                    wr  = 1'b1;
                    res = addr;
                end
                enc_lw: begin
                    wr  = 1'b1;
                    res = mem[addr[7:0]];
                end
                enc_sw: begin
                    mem[addr[7:0]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                enc_beq: if (a == b) pc = pc + imm;
                enc_bne: if (a != b) pc = pc + imm;
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
            end
            steps++;
        end
    endfunction

    // compares each store with the reference list
    always @(posedge clk) begin
        if (checking && dmem_we === 1'b1) begin
            stores_seen++;
            if (exp_addr.size() == 0) begin
                $display("unexpected store of 0x%08h to address 0x%08h", dmem_wdata, dmem_addr);
                errors++;
            end else begin
                check_value("dmem_addr", dmem_addr, exp_addr.pop_front());
                check_value("dmem_wdata", dmem_wdata, exp_data.pop_front());
            end
        end
    end

    // **************************************************
    // test sequencing
    // **************************************************

    task automatic begin_program();
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);  // dut now in reset
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end
        prog_len = 0;
    endtask

    task automatic run_program(input string name);
        int start_errors;
        int cycles;
        start_errors = errors;
        emit_i(enc_beq, 0, 0, -1);
        reference_stores();
        stores_seen = 0;
        for (int i = 0; i < 9; i++) begin
            @(negedge clk);
            check_value("imem_addr", imem_addr, 32'h0);
        end
        checking = 1'b1;
        @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_addr.size() != 0) begin
            $display("%s timed out waiting for stores", name);
            errors++;
        end
        // late wrong-path stores would show up while the self-loop spins
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
        end
        checking = 1'b0;
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("%-12s %0d stores, %s", name, stores_seen,
                 (errors == start_errors) ? "ok" : "mismatch");
    endtask

    task automatic alu_chain_test();
        begin_program();
        emit_i(enc_addiu, 1, 0, 16'h1234);
        emit_i(enc_addiu, 2, 1, 16'hff00);  // depends on previous
        emit_i(enc_sw, 2, 0, 0);
        emit_r(enc_addu, 3, 1, 2);
        emit_i(enc_sw, 3, 0, 1);
        emit_r(enc_subu, 4, 3, 1);
        emit_i(enc_sw, 4, 0, 2);
        emit_r(enc_and, 5, 4, 3);
        emit_i(enc_sw, 5, 0, 3);
        emit_r(enc_or, 6, 5, 2);
        emit_i(enc_sw, 6, 0, 4);
        emit_r(enc_slt, 7, 2, 6);
        emit_i(enc_sw, 7, 0, 5);
        emit_r(enc_slt, 8, 6, 2);
        emit_i(enc_sw, 8, 0, 6);
        emit_i(enc_addiu, 9, 8, 16'h8000);
        emit_i(enc_sw, 9, 0, 7);
        emit_r(enc_subu, 10, 0, 9);
        emit_r(enc_addu, 11, 10, 9);
        emit_r(enc_subu, 12, 11, 10);       // mem and wb forward together
        emit_i(enc_sw, 10, 0, 8);
        emit_i(enc_sw, 12, 0, 9);
        emit_i(enc_sw, 11, 0, 10);
        run_program("alu_chain");
    endtask

    task automatic load_use_test();
        begin_program();
        emit_i(enc_lw, 1, 0, 3);
        emit_r(enc_addu, 2, 1, 1);   // uses load right away
        emit_i(enc_sw, 2, 0, 16);
        emit_i(enc_lw, 3, 0, 4);
        emit_i(enc_sw, 3, 0, 17);    // load data straight to store
        emit_i(enc_lw, 4, 0, 5);
        emit_i(enc_addiu, 5, 4, 7);
        emit_i(enc_sw, 5, 0, 6);
        emit_i(enc_lw, 6, 0, 6);     // reads back the store above
        emit_r(enc_subu, 7, 6, 4);
        emit_i(enc_sw, 7, 0, 19);
        emit_i(enc_addiu, 10, 0, 20);
        emit_i(enc_lw, 11, 10, 2);   // base from previous result
        emit_r(enc_slt, 12, 11, 1);
        emit_i(enc_sw, 12, 0, 21);
        emit_i(enc_sw, 11, 0, 22);
        run_program("load_use");
    endtask

    task automatic branch_test();
        begin_program();
        emit_i(enc_addiu, 1, 0, 7);
        emit_i(enc_addiu, 2, 0, 7);
        emit_i(enc_beq, 2, 1, 1);    // taken
        emit_i(enc_sw, 1, 0, 32);
        emit_i(enc_sw, 2, 0, 33);
        emit_i(enc_addiu, 3, 0, 9);
        emit_i(enc_bne, 1, 3, 2);    // taken and skips two
        emit_i(enc_sw, 3, 0, 34);
        emit_i(enc_sw, 3, 0, 35);
        emit_i(enc_sw, 3, 0, 36);
        emit_i(enc_addiu, 4, 0, 7);
        emit_i(enc_beq, 3, 4, 1);    // not taken
        emit_i(enc_sw, 4, 0, 37);
        emit_i(enc_bne, 1, 4, 1);    // not taken
        emit_i(enc_sw, 1, 0, 38);
        emit_i(enc_lw, 5, 0, 2);
        emit_i(enc_addiu, 6, 0, 0);
        emit_i(enc_bne, 6, 5, 1);    // load two ahead of the branch
        emit_i(enc_sw, 5, 0, 39);
        emit_i(enc_sw, 6, 0, 40);
        emit_i(enc_beq, 0, 0, 1);
        emit_i(enc_sw, 0, 0, 41);
        emit_r(enc_subu, 7, 1, 3);
        emit_r(enc_slt, 8, 7, 0);
        emit_i(enc_bne, 0, 8, 1);
        emit_i(enc_sw, 7, 0, 42);
        emit_i(enc_sw, 8, 0, 43);
        run_program("branches");
    endtask

    task automatic random_test(input int idx);
        int count;
        int kind;
        int rd;
        int rs;
        int rt;
        begin_program();
        for (int r = 1; r <= 4; r++) begin
            emit_i(enc_addiu, r, 0, rand_imm());
        end
        count = 8 + int'($urandom_range(8, 0));
        for (int i = 0; i < count; i++) begin
            kind = int'($urandom_range(5, 0));
            rd   = int'($urandom_range(4, 1));
            rs   = int'($urandom_range(4, 1));
            rt   = int'($urandom_range(4, 1));
            case (kind)
                0:       emit_r(enc_addu, rd, rs, rt);
                1:       emit_r(enc_subu, rd, rs, rt);
                2:       emit_r(enc_and, rd, rs, rt);
                3:       emit_r(enc_or, rd, rs, rt);
                4:       emit_r(enc_slt, rd, rs, rt);
                default: emit_i(enc_addiu, rd, rs, rand_imm());
            endcase
        end
        for (int r = 1; r <= 4; r++) begin
            emit_i(enc_sw, r, 0, r);
        end
        run_program($sformatf("random_%0d", idx));
    endtask

    initial begin
        void'($urandom(32'h4f1));
        errors       = 0;
        stores_seen  = 0;
        tests_run    = 0;
        tests_failed = 0;
        prog_len     = 0;
        checking     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end
        reset <= 1'b1;

        alu_chain_test();
        load_use_test();
        branch_test();
        for (int p = 0; p < 50; p++) begin
            random_test(p);
        end

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- logic/alu.sv
module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_e op,
    output mips_pkg::word_t   result
);

    logic less_than;

    // signed compare for slt
    assign less_than = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::alu_add: result = a + b;
            mips_pkg::alu_sub: result = a - b;
            mips_pkg::alu_and: result = a & b;
            mips_pkg::alu_or:  result = a | b;
            mips_pkg::alu_slt: begin
                result = '0;
                result[0] = less_than;
            end
            default: result = '0;  // unused encodings
        endcase
    end

endmodule

//--- logic/decode_ctrl.sv
module decode_ctrl (
    input  mips_pkg::opcode_e opcode,
    input  mips_pkg::funct_e  funct,
    input  logic              rs_equal,
    output mips_pkg::ctrl_t   ctrl,
    output logic              branch,
    output logic              branch_taken
);

    always_comb begin
        ctrl        = '0;  // no-op unless matched below
        ctrl.alu_op = mips_pkg::alu_add;
        branch      = 1'b0;

        case (opcode)
            mips_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (funct)
                    mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    default: begin
                        ctrl.reg_write = 1'b0;  // unknown funct
                        ctrl.reg_dst   = 1'b0;
                    end
                endcase
            end
            mips_pkg::op_addiu: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            mips_pkg::op_sw: begin
                ctrl.alu_src   = 1'b1;  // address = rs + imm
                ctrl.mem_write = 1'b1;
            end
            mips_pkg::op_beq,
            mips_pkg::op_bne: begin
                branch = 1'b1;  // resolved here, nothing goes down the pipe
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // comparison is done on the forwarded decode operands
    assign branch_taken = (opcode == mips_pkg::op_beq &&  rs_equal) ||
                          (opcode == mips_pkg::op_bne && !rs_equal);

endmodule

//--- logic/hazard_unit.sv
module hazard_unit (
    input  mips_pkg::reg_addr_t rs_d,
    input  mips_pkg::reg_addr_t rt_d,
    input  mips_pkg::reg_addr_t rs_e,
    input  mips_pkg::reg_addr_t rt_e,
    input  mips_pkg::reg_addr_t write_reg_e,
    input  mips_pkg::reg_addr_t write_reg_m,
    input  mips_pkg::reg_addr_t write_reg_w,
    input  logic                reg_write_e,
    input  logic                mem_to_reg_e,
    input  logic                reg_write_m,
    input  logic                mem_to_reg_m,
    input  logic                reg_write_w,
    input  logic                branch_d,
    input  logic                branch_taken_d,
    output mips_pkg::fwd_sel_e  fwd_a_e,
    output mips_pkg::fwd_sel_e  fwd_b_e,
    output logic                fwd_a_d,
    output logic                fwd_b_d,
    output logic                stall,
    output logic                flush_d
);

    logic load_stall;
    logic branch_stall;

    // memory stage wins over writeback, $0 never forwarded
    function automatic mips_pkg::fwd_sel_e pick_src(
        input mips_pkg::reg_addr_t src,
        input mips_pkg::reg_addr_t dst_m,
        input logic                we_m,
        input mips_pkg::reg_addr_t dst_w,
        input logic                we_w
    );
        if (src == '0) begin
            return mips_pkg::fwd_none;
        end else if (we_m && src == dst_m) begin
            return mips_pkg::fwd_mem;
        end else if (we_w && src == dst_w) begin
            return mips_pkg::fwd_wb;
        end
        return mips_pkg::fwd_none;
    endfunction

    assign fwd_a_e = pick_src(rs_e, write_reg_m, reg_write_m, write_reg_w, reg_write_w);
    assign fwd_b_e = pick_src(rt_e, write_reg_m, reg_write_m, write_reg_w, reg_write_w);

    // decode forwarding for the branch compare
    assign fwd_a_d = (rs_d != '0) && reg_write_m && (rs_d == write_reg_m);
    assign fwd_b_d = (rt_d != '0) && reg_write_m && (rt_d == write_reg_m);

    // load in execute feeding the instruction in decode
    assign load_stall = mem_to_reg_e && (rs_d == write_reg_e || rt_d == write_reg_e);

    // branch operand still in flight
    assign branch_stall = branch_d && (
        (reg_write_e  && (rs_d == write_reg_e || rt_d == write_reg_e)) ||
        (mem_to_reg_m && (rs_d == write_reg_m || rt_d == write_reg_m)));

    assign stall   = load_stall || branch_stall;
    assign flush_d = branch_taken_d && !stall;  // stall has priority

endmodule

//--- logic/mips_pkg.sv
package mips_pkg;

    // **************************************************
    // widths and base types
    // **************************************************

    parameter int xlen       = 32;
    parameter int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // **************************************************
    // instruction encodings
    // **************************************************

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    // operand source for the execute stage muxes
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

    // **************************************************
    // control word and stage registers
    // **************************************************

    typedef struct packed {
        logic    reg_write;
        logic    reg_dst;    // rd instead of rt
        logic    alu_src;    // immediate as operand b
        alu_op_e alu_op;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        word_t pc_next;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs_data;
        word_t     rt_data;
        word_t     sign_imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     write_data;  // store data
        reg_addr_t write_reg;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     read_data;
        reg_addr_t write_reg;
    } mem_wb_t;

endpackage

//--- logic/pipe_cpu.sv
module pipe_cpu #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    output mips_pkg::word_t imem_addr,
    input  mips_pkg::word_t imem_data,
    output mips_pkg::word_t dmem_addr,
    output logic            dmem_we,
    output mips_pkg::word_t dmem_wdata,
    input  mips_pkg::word_t dmem_rdata
);

    // fetch
    mips_pkg::word_t     pc_f;
    mips_pkg::word_t     pc_plus1_f;
    mips_pkg::word_t     pc_new_f;

    // stage registers
    mips_pkg::if_id_t    if_id_q;
    mips_pkg::id_ex_t    id_ex_d;
    mips_pkg::id_ex_t    id_ex_q;
    mips_pkg::ex_mem_t   ex_mem_d;
    mips_pkg::ex_mem_t   ex_mem_q;
    mips_pkg::mem_wb_t   mem_wb_d;
    mips_pkg::mem_wb_t   mem_wb_q;

    // decode
    mips_pkg::word_t     instr_d;
    mips_pkg::reg_addr_t rs_d;
    mips_pkg::reg_addr_t rt_d;
    mips_pkg::reg_addr_t rd_d;
    mips_pkg::word_t     sign_imm_d;
    mips_pkg::word_t     branch_target_d;
    mips_pkg::word_t     rs_data_d;
    mips_pkg::word_t     rt_data_d;
    mips_pkg::word_t     rs_fwd_d;
    mips_pkg::word_t     rt_fwd_d;
    mips_pkg::ctrl_t     ctrl_d;
    logic                branch_d;
    logic                branch_taken_d;

    // execute
    mips_pkg::word_t     src_a_e;
    mips_pkg::word_t     write_data_e;
    mips_pkg::word_t     src_b_e;
    mips_pkg::word_t     alu_result_e;
    mips_pkg::reg_addr_t write_reg_e;

    // writeback
    mips_pkg::word_t     result_w;

    // hazards
    mips_pkg::fwd_sel_e  fwd_a_e;
    mips_pkg::fwd_sel_e  fwd_b_e;
    logic                fwd_a_d;
    logic                fwd_b_d;
    logic                stall;
    logic                flush_d;

    function automatic mips_pkg::word_t fwd_mux(
        input mips_pkg::fwd_sel_e sel,
        input mips_pkg::word_t    reg_val,
        input mips_pkg::word_t    mem_val,
        input mips_pkg::word_t    wb_val
    );
        case (sel)
            mips_pkg::fwd_mem: return mem_val;
            mips_pkg::fwd_wb:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    // **************************************************
    // fetch
    // **************************************************

    assign pc_plus1_f = pc_f + 32'd1;  // word addressed
    assign pc_new_f   = branch_taken_d ? branch_target_d : pc_plus1_f;
    assign imem_addr  = pc_f;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_f <= RESET_PC;
        end else if (!stall) begin
            pc_f <= pc_new_f;
        end
    end

    // flush_d is already masked by stall
    always_ff @(posedge clk) begin
        if (reset || flush_d) begin
            if_id_q <= '0;  // all-zero word decodes as no-op
        end else if (!stall) begin
            if_id_q.pc_next <= pc_plus1_f;
            if_id_q.instr   <= imem_data;
        end
    end

    // **************************************************
    // decode
    // **************************************************

    assign instr_d         = if_id_q.instr;
    assign rs_d            = instr_d[25:21];
    assign rt_d            = instr_d[20:16];
    assign rd_d            = instr_d[15:11];
    assign sign_imm_d      = {{16{instr_d[15]}}, instr_d[15:0]};
    assign branch_target_d = if_id_q.pc_next + sign_imm_d;

    reg_file reg_file_i (
        .clk     (clk),
        .reset   (reset),
        .rs      (rs_d),
        .rt      (rt_d),
        .rs_data (rs_data_d),
        .rt_data (rt_data_d),
        .wr_addr (mem_wb_q.write_reg),
        .wr_data (result_w),
        .wr_en   (mem_wb_q.reg_write)
    );

    // early compare operands
    assign rs_fwd_d = fwd_a_d ? ex_mem_q.alu_result : rs_data_d;
    assign rt_fwd_d = fwd_b_d ? ex_mem_q.alu_result : rt_data_d;

    decode_ctrl decode_ctrl_i (
        .opcode       (mips_pkg::opcode_e'(instr_d[31:26])),
        .funct        (mips_pkg::funct_e'(instr_d[5:0])),
        .rs_equal     (rs_fwd_d == rt_fwd_d),
        .ctrl         (ctrl_d),
        .branch       (branch_d),
        .branch_taken (branch_taken_d)
    );

    always_comb begin
        id_ex_d.ctrl     = ctrl_d;
        id_ex_d.rs_data  = rs_data_d;
        id_ex_d.rt_data  = rt_data_d;
        id_ex_d.sign_imm = sign_imm_d;
        id_ex_d.rs       = rs_d;
        id_ex_d.rt       = rt_d;
        id_ex_d.rd       = rd_d;
    end

    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_d;
        if (reset || stall) begin
            id_ex_q.ctrl <= '0;  // bubble
        end
    end

    // **************************************************
    // execute
    // **************************************************

    assign src_a_e      = fwd_mux(fwd_a_e, id_ex_q.rs_data, ex_mem_q.alu_result, result_w);
    assign write_data_e = fwd_mux(fwd_b_e, id_ex_q.rt_data, ex_mem_q.alu_result, result_w);
    assign src_b_e      = id_ex_q.ctrl.alu_src ? id_ex_q.sign_imm : write_data_e;
    assign write_reg_e  = id_ex_q.ctrl.reg_dst ? id_ex_q.rd : id_ex_q.rt;

    alu alu_i (
        .a      (src_a_e),
        .b      (src_b_e),
        .op     (id_ex_q.ctrl.alu_op),
        .result (alu_result_e)
    );

    always_comb begin
        ex_mem_d.reg_write  = id_ex_q.ctrl.reg_write;
        ex_mem_d.mem_write  = id_ex_q.ctrl.mem_write;
        ex_mem_d.mem_to_reg = id_ex_q.ctrl.mem_to_reg;
        ex_mem_d.alu_result = alu_result_e;
        ex_mem_d.write_data = write_data_e;
        ex_mem_d.write_reg  = write_reg_e;
    end

    always_ff @(posedge clk) begin
        ex_mem_q <= ex_mem_d;
        if (reset) begin
            ex_mem_q.reg_write  <= 1'b0;
            ex_mem_q.mem_write  <= 1'b0;
            ex_mem_q.mem_to_reg <= 1'b0;
        end
    end

    // **************************************************
    // memory
    // **************************************************

    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_we    = ex_mem_q.mem_write;
    assign dmem_wdata = ex_mem_q.write_data;

    always_comb begin
        mem_wb_d.reg_write  = ex_mem_q.reg_write;
        mem_wb_d.mem_to_reg = ex_mem_q.mem_to_reg;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.read_data  = dmem_rdata;
        mem_wb_d.write_reg  = ex_mem_q.write_reg;
    end

    always_ff @(posedge clk) begin
        mem_wb_q <= mem_wb_d;
        if (reset) begin
            mem_wb_q.reg_write  <= 1'b0;
            mem_wb_q.mem_to_reg <= 1'b0;
        end
    end

    // **************************************************
    // writeback and hazards
    // **************************************************

    assign result_w = mem_wb_q.mem_to_reg ? mem_wb_q.read_data : mem_wb_q.alu_result;

    hazard_unit hazard_unit_i (
        .rs_d           (rs_d),
        .rt_d           (rt_d),
        .rs_e           (id_ex_q.rs),
        .rt_e           (id_ex_q.rt),
        .write_reg_e    (write_reg_e),
        .write_reg_m    (ex_mem_q.write_reg),
        .write_reg_w    (mem_wb_q.write_reg),
        .reg_write_e    (id_ex_q.ctrl.reg_write),
        .mem_to_reg_e   (id_ex_q.ctrl.mem_to_reg),
        .reg_write_m    (ex_mem_q.reg_write),
        .mem_to_reg_m   (ex_mem_q.mem_to_reg),
        .reg_write_w    (mem_wb_q.reg_write),
        .branch_d       (branch_d),
        .branch_taken_d (branch_taken_d),
        .fwd_a_e        (fwd_a_e),
        .fwd_b_e        (fwd_b_e),
        .fwd_a_d        (fwd_a_d),
        .fwd_b_d        (fwd_b_d),
        .stall          (stall),
        .flush_d        (flush_d)
    );

endmodule

//--- logic/reg_file.sv
module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    input  logic                wr_en
);

    mips_pkg::word_t regs [1:31];  // $0 is not stored

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so decode sees the value being written back
    assign rs_data = (rs == '0) ? '0 :
                     (wr_en && wr_addr == rs) ? wr_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (wr_en && wr_addr == rt) ? wr_data : regs[rt];

endmodule

//--- project.f
logic/mips_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/decode_ctrl.sv
logic/hazard_unit.sv
logic/pipe_cpu.sv
dv/pipe_cpu_tb.sv
